/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_ram_tb
RTL_TOP   ?= axi_ram_top
FILELIST  ?= axi_ram_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* axi_ram_sys.f */
+incdir+include
design/axi_ram_pkg.sv
design/mem_req_if.sv
design/axi_req_decode.sv
design/ram_array.sv
design/axi_resp_gen.sv
design/axi_ram_top.sv
tb/axi_ram_chk.sv
tb/axi_ram_tb.sv

/* design/axi_ram_pkg.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

package axi_ram_pkg;

  // derived widths of the data path.
  localparam int STRB_W = `AXI_RAM_DW / 8;
  localparam int OFF_W  = $clog2(STRB_W);
  localparam int WORD_W = `AXI_RAM_AW - OFF_W;

  // ========================================================================
  // response codes
  // ========================================================================

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // ========================================================================
  // address word, seen as a raw byte address or split for indexing
  // ========================================================================

  typedef struct packed {
    logic [31-`AXI_RAM_AW:0] region;
    logic [WORD_W-1:0]       word;
    logic [OFF_W-1:0]        offset;
  } axi_addr_s;

  typedef union packed {
    logic [31:0] raw;
    axi_addr_s   fields;
  } axi_addr_u;

endpackage

`default_nettype wire

/* design/axi_ram_top.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_ram_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     aw_valid_i,
  input  logic [31:0]              aw_addr_i,
  output logic                     aw_ready_o,
  input  logic                     w_valid_i,
  input  logic [`AXI_RAM_DW-1:0]   w_data_i,
  input  logic [`AXI_RAM_DW/8-1:0] w_strb_i,
  output logic                     w_ready_o,
  output logic                     b_valid_o,
  output logic [1:0]               b_resp_o,
  input  logic                     b_ready_i,
  input  logic                     ar_valid_i,
  input  logic [31:0]              ar_addr_i,
  output logic                     ar_ready_o,
  output logic                     r_valid_o,
  output logic [`AXI_RAM_DW-1:0]   r_data_o,
  output logic [1:0]               r_resp_o,
  input  logic                     r_ready_i
);

  logic [`AXI_RAM_DW-1:0] rdata;
  logic                   b_busy;
  logic                   r_busy;

  mem_req_if u_mem_if ();

  axi_req_decode u_dec (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_ready_o  (w_ready_o),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_ready_o (ar_ready_o),
    .b_busy_i   (b_busy),
    .r_busy_i   (r_busy),
    .mem_o      (u_mem_if.dec)
  );

  ram_array u_ram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .mem_i    (u_mem_if.exe),
    .rdata_o  (rdata)
  );

  axi_resp_gen u_resp (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .mem_i     (u_mem_if.res),
    .rdata_i   (rdata),
    .b_valid_o (b_valid_o),
    .b_resp_o  (b_resp_o),
    .b_ready_i (b_ready_i),
    .r_valid_o (r_valid_o),
    .r_data_o  (r_data_o),
    .r_resp_o  (r_resp_o),
    .r_ready_i (r_ready_i),
    .b_busy_o  (b_busy),
    .r_busy_o  (r_busy)
  );

endmodule

`default_nettype wire

/* design/axi_req_decode.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_req_decode (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     aw_valid_i,
  input  axi_ram_pkg::axi_addr_u   aw_addr_i,
  output logic                     aw_ready_o,
  input  logic                     w_valid_i,
  input  logic [`AXI_RAM_DW-1:0]   w_data_i,
  input  logic [`AXI_RAM_DW/8-1:0] w_strb_i,
  output logic                     w_ready_o,
  input  logic                     ar_valid_i,
  input  axi_ram_pkg::axi_addr_u   ar_addr_i,
  output logic                     ar_ready_o,
  input  logic                     b_busy_i,
  input  logic                     r_busy_i,
  mem_req_if.dec                   mem_o
);
  import axi_ram_pkg::*;

  localparam bit WRITES_ON = (`AXI_RAM_ALLOW_WRITES != 0);

  logic rdy_en_q;
  logic wr_ready;
  logic wr_fire;
  logic ar_fire;
  logic wr_err;
  logic rd_err;

  // true when the byte address falls inside [BASE, BASE + 2**AW).
  function automatic logic in_window(input axi_addr_u addr);
    logic [32:0] off;
    off = {1'b0, addr.raw} - {1'b0, `AXI_RAM_BASE};
    return !off[32] && (off[31:`AXI_RAM_AW] == '0);
  endfunction

  // ==========================================================================
  // handshakes
  // ==========================================================================

  // AW and W are taken together, one write at a time.
  // the strobe registers double as the in-flight flags.
  assign wr_ready   = rdy_en_q & aw_valid_i & w_valid_i & ~mem_o.we & ~b_busy_i;
  assign aw_ready_o = wr_ready;
  assign w_ready_o  = wr_ready;
  assign ar_ready_o = rdy_en_q & ~mem_o.re & ~r_busy_i;

  assign wr_fire = wr_ready;
  assign ar_fire = ar_valid_i & ar_ready_o;

  assign wr_err = ~in_window(aw_addr_i) | ~WRITES_ON;
  assign rd_err = ~in_window(ar_addr_i);

  // ==========================================================================
  // strobes
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdy_en_q <= 1'b0;
      mem_o.we <= 1'b0;
      mem_o.re <= 1'b0;
    end else begin
      rdy_en_q <= 1'b1;
      mem_o.we <= wr_fire;
      mem_o.re <= ar_fire;
    end
  end

  // request payload, captured on the accepting edge.
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_o.waddr <= aw_addr_i.fields.word;
      mem_o.wdata <= w_data_i;
      // a rejected write still pulses, but touches no lane.
      mem_o.wstrb <= wr_err ? '0 : w_strb_i;
      mem_o.werr  <= wr_err;
    end
    if (ar_fire) begin
      mem_o.raddr <= ar_addr_i.fields.word;
      mem_o.rerr  <= rd_err;
    end
  end

endmodule

`default_nettype wire

/* design/axi_resp_gen.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_resp_gen (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  mem_req_if.res                 mem_i,
  input  logic [`AXI_RAM_DW-1:0] rdata_i,
  output logic                   b_valid_o,
  output axi_ram_pkg::axi_resp_e b_resp_o,
  input  logic                   b_ready_i,
  output logic                   r_valid_o,
  output logic [`AXI_RAM_DW-1:0] r_data_o,
  output axi_ram_pkg::axi_resp_e r_resp_o,
  input  logic                   r_ready_i,
  output logic                   b_busy_o,
  output logic                   r_busy_o
);
  import axi_ram_pkg::*;

  logic      b_valid_q;
  logic      r_valid_q;
  axi_resp_e b_resp_q;
  axi_resp_e r_resp_q;

  // ==========================================================================
  // valid flags
  // ==========================================================================

  // a new pulse cannot arrive while a response is still held.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (mem_i.we) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (mem_i.re) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // response codes, latched with the strobe.
  always_ff @(posedge clk_i) begin
    if (mem_i.we) begin
      b_resp_q <= mem_i.werr ? RESP_SLVERR : RESP_OKAY;
    end
    if (mem_i.re) begin
      r_resp_q <= mem_i.rerr ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;
  assign r_valid_o = r_valid_q;
  assign r_resp_o  = r_resp_q;

  // the storage keeps its read register until the next read,
  // so the data stays stable while R is held.
  assign r_data_o = (r_resp_q == RESP_SLVERR) ? '0 : rdata_i;

  // busy from the strobe cycle until the response is taken.
  assign b_busy_o = mem_i.we | b_valid_q;
  assign r_busy_o = mem_i.re | r_valid_q;

endmodule

`default_nettype wire

/* design/mem_req_if.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

interface mem_req_if;
  import axi_ram_pkg::*;

  // write strobe and payload.
  logic                   we;
  logic [WORD_W-1:0]      waddr;
  logic [`AXI_RAM_DW-1:0] wdata;
  logic [STRB_W-1:0]      wstrb;
  logic                   werr;

  // read strobe and payload.
  logic                   re;
  logic [WORD_W-1:0]      raddr;
  logic                   rerr;

  modport dec (output we, waddr, wdata, wstrb, werr, re, raddr, rerr);
  modport exe (input we, waddr, wdata, wstrb, re, raddr);
  modport res (input we, werr, re, rerr);

endinterface

`default_nettype wire

/* design/ram_array.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module ram_array (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  mem_req_if.exe                 mem_i,
  output logic [`AXI_RAM_DW-1:0] rdata_o
);
  import axi_ram_pkg::*;

  localparam int DEPTH = 2 ** WORD_W;

  logic [STRB_W-1:0][7:0] rdata_q;

  // ==========================================================================
  // one storage column per byte lane
  // ==========================================================================

  for (genvar l = 0; l < STRB_W; l++) begin : g_lane
    logic [7:0] lane_mem [DEPTH];

    // strobed write of this lane.
    always_ff @(posedge clk_i) begin
      if (mem_i.we && mem_i.wstrb[l]) begin
        lane_mem[mem_i.waddr] <= mem_i.wdata[8*l +: 8];
      end
    end

    // read register, sees the old word on a same-cycle write.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rdata_q[l] <= 8'h00;
      end else if (mem_i.re) begin
        rdata_q[l] <= lane_mem[mem_i.raddr];
      end
    end
  end

  // held until the next read strobe.
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* include/axi_ram_cfg.svh */
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

// ==========================================================================
// memory window and data path configuration
// ==========================================================================

// first byte address of the memory window.
`define AXI_RAM_BASE 32'h0000_1000

// address bits inside the window, the window spans 2**AW bytes.
`define AXI_RAM_AW 10

// data bus width in bits.
`define AXI_RAM_DW 32

// 0 makes the memory read-only, every write then gets SLVERR.
`define AXI_RAM_ALLOW_WRITES 1

`endif

/* tb/axi_ram_chk.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_ram_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   aw_valid_i,
  input logic                   aw_ready_o,
  input logic                   ar_valid_i,
  input logic                   ar_ready_o,
  input logic                   b_valid_o,
  input logic [1:0]             b_resp_o,
  input logic                   b_ready_i,
  input logic                   r_valid_o,
  input logic [`AXI_RAM_DW-1:0] r_data_o,
  input logic [1:0]             r_resp_o,
  input logic                   r_ready_i
);

  int fail_cnt = 0;

  // ==========================================================================
  // held responses
  // ==========================================================================

  b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else begin
      fail_cnt++;
      $error("B response changed before it was taken");
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else begin
      fail_cnt++;
      $error("R response changed before it was taken");
    end

  // ==========================================================================
  // response latency and reset state
  // ==========================================================================

  // valid is first sampled high on the second edge after the handshake.
  b_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i && aw_ready_o |=> !b_valid_o ##1 b_valid_o)
    else begin
      fail_cnt++;
      $error("B response not 2 cycles after the AW handshake");
    end

  r_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_i && ar_ready_o |=> !r_valid_o ##1 r_valid_o)
    else begin
      fail_cnt++;
      $error("R response not 2 cycles after the AR handshake");
    end

  rst_low: assert property (@(posedge clk_i)
    !arst_n_i |-> !b_valid_o && !r_valid_o && !aw_ready_o && !ar_ready_o)
    else begin
      fail_cnt++;
      $error("handshake output high during reset");
    end

endmodule

bind axi_ram_top axi_ram_chk u_chk (.*);

`default_nettype wire

/* tb/axi_ram_tb.sv */
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_ram_tb;
  import axi_ram_pkg::*;

  localparam int DW     = `AXI_RAM_DW;
  localparam int NBYTES = 2 ** `AXI_RAM_AW;
  localparam int N_RAND = 24;
  // worst-case cycles of one access, and the access count of all tests.
  localparam int OP_CYC = 8;
  localparam int N_OPS  = 12 + 9 + 7 + 3 + N_RAND;
  localparam int WD_CYC = 5 + N_OPS * OP_CYC + 50;

  logic            clk;
  logic            arst_n;
  logic            aw_valid;
  logic            w_valid;
  logic            ar_valid;
  logic            b_ready;
  logic            r_ready;
  logic [31:0]     aw_addr;
  logic [31:0]     ar_addr;
  logic [DW-1:0]   w_data;
  logic [DW/8-1:0] w_strb;
  logic            aw_ready;
  logic            w_ready;
  logic            ar_ready;
  logic            b_valid;
  logic            r_valid;
  logic [1:0]      b_resp;
  logic [1:0]      r_resp;
  logic [DW-1:0]   r_data;

  // byte-wise reference model, known marks bytes with a defined value.
  logic [7:0]  ref_mem [NBYTES];
  bit          ref_known [NBYTES];
  logic [31:0] lcg_state = 32'd16219;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          start;

  axi_ram_top UUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .aw_valid_i (aw_valid),
    .aw_addr_i  (aw_addr),
    .aw_ready_o (aw_ready),
    .w_valid_i  (w_valid),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid),
    .b_resp_o   (b_resp),
    .b_ready_i  (b_ready),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .r_ready_i  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(WD_CYC * 40);
    $display("run timed out after %0d cycles, a handshake or response never came", WD_CYC);
    $display("Verification failed");
    $finish;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic bit in_window(input logic [31:0] addr);
    return addr >= `AXI_RAM_BASE && addr < `AXI_RAM_BASE + 32'(NBYTES);
  endfunction

  function automatic int word_base(input logic [31:0] addr);
    return int'(addr - `AXI_RAM_BASE) & ~(DW / 8 - 1);
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    tests++;
    $display("test %-14s %s, %0d errors", name,
             (errors == first_err) ? "ok" : "FAILED", errors - first_err);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [DW-1:0] data,
                            input logic [DW/8-1:0] strb);
    axi_resp_e exp;
    int        cyc;
    int        base;
    exp = (in_window(addr) && `AXI_RAM_ALLOW_WRITES != 0) ? RESP_OKAY : RESP_SLVERR;
    aw_addr = addr;
    w_data = data;
    w_strb = strb;
    aw_valid = 1'b1;
    w_valid = 1'b1;
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    if (!w_ready) begin
      report_error("w_ready_o low while aw_ready_o was high");
    end
    @(posedge clk);
    #2;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!b_valid && cyc < OP_CYC);
    if (!b_valid) begin
      report_error($sformatf("no write response for address 0x%h", addr));
    end else if (cyc != 2) begin
      report_error($sformatf("write response after %0d cycles, expected 2", cyc));
    end
    check_resp("b_resp_o", axi_resp_e'(b_resp), exp);
    if (exp == RESP_OKAY) begin
      base = word_base(addr);
      for (int b = 0; b < DW / 8; b++) begin
        if (strb[b]) begin
          ref_mem[base + b] = data[8*b +: 8];
          ref_known[base + b] = 1'b1;
        end
      end
    end
    while (!b_ready) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // the expected word is taken from the model before the request goes out.
  task automatic read_word(input logic [31:0] addr);
    logic [DW-1:0] exp;
    logic [DW-1:0] mask;
    bit            ok;
    int            cyc;
    int            base;
    ok = in_window(addr);
    base = word_base(addr);
    exp = '0;
    mask = '1;
    if (ok) begin
      for (int b = 0; b < DW / 8; b++) begin
        exp[8*b +: 8] = ref_mem[base + b];
        mask[8*b +: 8] = ref_known[base + b] ? 8'hff : 8'h00;
      end
    end
    ar_addr = addr;
    ar_valid = 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    @(posedge clk);
    #2;
    ar_valid = 1'b0;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!r_valid && cyc < OP_CYC);
    if (!r_valid) begin
      report_error($sformatf("no read response for address 0x%h", addr));
    end else if (cyc != 2) begin
      report_error($sformatf("read response after %0d cycles, expected 2", cyc));
    end
    check_resp("r_resp_o", axi_resp_e'(r_resp), ok ? RESP_OKAY : RESP_SLVERR);
    check_data("r_data_o", r_data & mask, exp & mask);
    // bytes never written take their first read value as reference.
    for (int b = 0; b < DW / 8; b++) begin
      if (ok && !ref_known[base + b]) begin
        ref_mem[base + b] = r_data[8*b +: 8];
        ref_known[base + b] = 1'b1;
      end
    end
    while (!r_ready) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic test_full_word();
    logic [31:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = `AXI_RAM_BASE + 32'(i * 68);
      read_word(addr);
      write_word(addr, DW'(lcg_next()), '1);
      read_word(addr);
    end
  endtask

  task automatic test_partial();
    logic [31:0]     addr;
    logic [DW/8-1:0] strbs [4];
    strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b0101};
    addr = `AXI_RAM_BASE + 32'h40;
    write_word(addr, DW'(lcg_next()), '1);
    for (int i = 0; i < 4; i++) begin
      write_word(addr, DW'(lcg_next()), strbs[i]);
      read_word(addr);
    end
  endtask

  task automatic test_window();
    logic [31:0] addr;
    addr = `AXI_RAM_BASE + 32'h8;
    read_word(addr);
    write_word(addr, DW'(lcg_next()), '1);
    // the second write aliases the word at addr inside the window.
    write_word(`AXI_RAM_BASE - 32'h4, DW'(lcg_next()), '1);
    write_word(`AXI_RAM_BASE + 32'(NBYTES) + 32'h8, DW'(lcg_next()), '1);
    read_word(`AXI_RAM_BASE - 32'h4);
    read_word(`AXI_RAM_BASE + 32'(NBYTES) + 32'h8);
    read_word(addr);
  endtask

  task automatic test_backpressure();
    logic [31:0]   addr;
    axi_resp_e     held_b;
    logic [DW-1:0] held_r;
    addr = `AXI_RAM_BASE + 32'h80;
    b_ready = 1'b0;
    r_ready = 1'b0;
    fork
      write_word(addr, DW'(lcg_next()), '1);
      read_word(addr + 32'h4);
      begin
        @(negedge clk);
        while (!(b_valid && r_valid)) @(negedge clk);
        held_b = axi_resp_e'(b_resp);
        held_r = r_data;
        @(posedge clk);
        #2;
        aw_valid = 1'b1;
        w_valid = 1'b1;
        ar_valid = 1'b1;
        repeat (6) begin
          @(negedge clk);
          if (!b_valid || !r_valid) report_error("held response dropped under back-pressure");
          if (aw_ready || w_ready || ar_ready) begin
            report_error("new request accepted while a response was held");
          end
          check_resp("b_resp_o", axi_resp_e'(b_resp), held_b);
          check_data("r_data_o", r_data, held_r);
        end
        @(posedge clk);
        #2;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;
      end
    join
  endtask

  task automatic test_random();
    logic [31:0]   waddr;
    logic [31:0]   raddr;
    logic [31:0]   pick;
    logic [DW-1:0] data;
    logic [31:0]   strb;
    for (int i = 0; i < N_RAND; i++) begin
      waddr = `AXI_RAM_BASE + ((lcg_next() >> 8) & 32'(NBYTES - 4));
      pick = lcg_next() >> 8;
      raddr = (pick[1:0] == 2'b00) ? waddr : `AXI_RAM_BASE + ((pick >> 2) & 32'(NBYTES - 4));
      data = DW'(lcg_next());
      strb = lcg_next() >> 12;
      fork
        write_word(waddr, data, strb[DW/8-1:0]);
        read_word(raddr);
      join
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    arst_n = 1'b0;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    ar_valid = 1'b0;
    aw_addr = '0;
    ar_addr = '0;
    w_data = '0;
    w_strb = '0;
    b_ready = 1'b1;
    r_ready = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(posedge clk);
    #2;
    start = errors;
    test_full_word();
    report_test("full_word", start);
    start = errors;
    test_partial();
    report_test("partial_strb", start);
    start = errors;
    test_window();
    report_test("window", start);
    start = errors;
    test_backpressure();
    report_test("backpressure", start);
    start = errors;
    test_random();
    report_test("random", start);
    errors += UUT.u_chk.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
